//--- hw/control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
    input  riscv_pkg::opcode_t opcode,
    input  riscv_pkg::funct3_t funct3,
    input  riscv_pkg::funct7_t funct7,
    output riscv_pkg::ctrl_t   ctrl
);
    import riscv_pkg::*;

    // Maps funct3 to an ALU operation; alt selects SUB or SRA.
    function automatic alu_op_t alu_from_funct3(funct3_t f3, logic alt);
        alu_op_t op;
        unique case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // Anything not listed below retires without a register write.
        ctrl = '{op1_sel: OP1_RS1, op2_sel: OP2_I_IMM, alu_op: ALU_ADD, we: 1'b0};

        unique case (opcode)
            OPC_OP: begin
                ctrl.op2_sel = OP2_RS2;
                ctrl.alu_op  = alu_from_funct3(funct3, funct7[5]);
                ctrl.we      = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only SRAI uses the funct7 bit. ADDI has no subtract form.
                ctrl.alu_op = alu_from_funct3(funct3, funct7[5] && (funct3 == 3'b101));
                ctrl.we     = 1'b1;
            end
            OPC_LUI: begin
                ctrl.op1_sel = OP1_ZERO;
                ctrl.op2_sel = OP2_U_IMM;
                ctrl.we      = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_U_IMM;
                ctrl.we      = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                // Only the link value is written. The stream is never redirected.
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_FOUR;
                ctrl.we      = 1'b1;
            end
            default: begin
                ctrl.we = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance,
    input  logic               in_valid,
    input  riscv_pkg::fetch_t  fetch,
    input  riscv_pkg::ctrl_t   ctrl,
    output riscv_pkg::opcode_t opcode,
    output riscv_pkg::funct3_t funct3,
    output riscv_pkg::funct7_t funct7,
    output riscv_pkg::reg_t    raddr1,
    output riscv_pkg::reg_t    raddr2,
    input  riscv_pkg::data_t   rdata1,
    input  riscv_pkg::data_t   rdata2,
    input  riscv_pkg::wb_t     ex_fwd,
    input  riscv_pkg::wb_t     wb_fwd,
    output riscv_pkg::id_ex_t  id_ex,
    output logic               id_ex_valid
);
    import riscv_pkg::*;

    ir_t   ir;
    imm_t  i_imm;
    imm_t  s_imm;
    imm_t  b_imm;
    imm_t  u_imm;
    imm_t  j_imm;
    data_t rs1_val;
    data_t rs2_val;
    data_t op1;
    data_t op2;

    // Picks the newest in-flight value for a source register.
    function automatic data_t forward(reg_t addr, data_t rf_data, wb_t ex, wb_t wb);
        data_t val;
        val = rf_data;
        if (addr != '0) begin
            if (ex.we && (ex.rd == addr)) begin
                val = ex.data;
            end else if (wb.we && (wb.rd == addr)) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    // ========================================================================
    // Field extraction and immediates
    // ========================================================================

    assign ir     = fetch.ir;
    assign opcode = ir.r.opcode;
    assign funct3 = ir.r.funct3;
    assign funct7 = ir.r.funct7;
    assign raddr1 = ir.r.rs1;
    assign raddr2 = ir.r.rs2;

    assign i_imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    assign s_imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
    assign b_imm = {{19{ir.sb.imm_12}}, ir.sb.imm_12, ir.sb.imm_11,
                    ir.sb.imm_10_5, ir.sb.imm_4_1, 1'b0};
    assign u_imm = {ir.u.imm_31_12, 12'd0};
    assign j_imm = {{11{ir.uj.imm_20}}, ir.uj.imm_20, ir.uj.imm_19_12,
                    ir.uj.imm_11, ir.uj.imm_10_1, 1'b0};

    // ========================================================================
    // Operand forwarding and selection
    // ========================================================================

    assign rs1_val = forward(raddr1, rdata1, ex_fwd, wb_fwd);
    assign rs2_val = forward(raddr2, rdata2, ex_fwd, wb_fwd);

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1 = rs1_val;
            OP1_PC:  op1 = fetch.pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2:   op2 = rs2_val;
            OP2_I_IMM: op2 = i_imm;
            OP2_S_IMM: op2 = s_imm;
            OP2_B_IMM: op2 = b_imm;
            OP2_U_IMM: op2 = u_imm;
            OP2_J_IMM: op2 = j_imm;
            OP2_FOUR:  op2 = 32'd4;
            default:   op2 = '0;
        endcase
    end

    // ID/EX register. An empty queue slot enters as a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex_valid <= 1'b0;
        end else if (advance) begin
            id_ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_ex <= '{op1: op1, op2: op2, alu_op: ctrl.alu_op, rd: ir.r.rd, we: ctrl.we};
        end
    end

endmodule

//--- hw/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              advance,
    input  riscv_pkg::id_ex_t id_ex,
    input  logic              id_ex_valid,
    output riscv_pkg::wb_t    ex_fwd,
    output logic              out_valid,
    output riscv_pkg::wb_t    out_data
);
    import riscv_pkg::*;

    data_t      result;
    logic [4:0] shamt;

    assign shamt = id_ex.op2[4:0];

    // ========================================================================
    // ALU
    // ========================================================================

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  result = id_ex.op1 + id_ex.op2;
            ALU_SUB:  result = id_ex.op1 - id_ex.op2;
            ALU_SLL:  result = id_ex.op1 << shamt;
            ALU_SLT:  result = {31'd0, $signed(id_ex.op1) < $signed(id_ex.op2)};
            ALU_SLTU: result = {31'd0, id_ex.op1 < id_ex.op2};
            ALU_XOR:  result = id_ex.op1 ^ id_ex.op2;
            ALU_SRL:  result = id_ex.op1 >> shamt;
            ALU_SRA:  result = data_t'($signed(id_ex.op1) >>> shamt);
            ALU_OR:   result = id_ex.op1 | id_ex.op2;
            ALU_AND:  result = id_ex.op1 & id_ex.op2;
            default:  result = '0;
        endcase
    end

    // A bubble never forwards and never writes back.
    assign ex_fwd = '{rd: id_ex.rd, data: result, we: id_ex.we && id_ex_valid};

    // Result register that drives the writeback port.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_data.we <= 1'b0;
        end else if (advance) begin
            out_valid <= id_ex_valid;
            out_data  <= ex_fwd;
        end
    end

endmodule

//--- hw/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  riscv_pkg::fetch_t in_data,
    input  logic              pop,
    output logic              empty,
    output riscv_pkg::fetch_t out_data
);
    import riscv_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_en;
    logic               pop_en;

    // The queue accepts whenever a slot is free and does not look at pop.
    assign in_ready = (count != CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign push_en  = in_valid && in_ready;
    assign pop_en   = pop && !empty;

    // Head entry is visible without waiting for a pop.
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged.
            if (push_en && !pop_en) begin
                count <= count + 1'b1;
            end else if (pop_en && !push_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic             clk,
    input  riscv_pkg::reg_t  raddr1,
    input  riscv_pkg::reg_t  raddr2,
    output riscv_pkg::data_t rdata1,
    output riscv_pkg::data_t rdata2,
    input  riscv_pkg::wb_t   wb,
    input  logic             wen
);
    import riscv_pkg::*;

    data_t regs [32];

    // Register 0 is forced to zero on the read side.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (wen && wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

//--- hw/riscv_pkg.sv
package riscv_pkg;

    // ========================================================================
    // Basic field types
    // ========================================================================

    typedef logic [31:0]        data_t;
    typedef logic [31:0]        pc_t;
    typedef logic [4:0]         reg_t;
    typedef logic [6:0]         opcode_t;
    typedef logic [2:0]         funct3_t;
    typedef logic [6:0]         funct7_t;
    typedef logic signed [31:0] imm_t;

    // Major opcodes handled by the datapath.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // ========================================================================
    // Instruction formats
    // ========================================================================

    typedef struct packed {
        funct7_t funct7;
        reg_t    rs2;
        reg_t    rs1;
        funct3_t funct3;
        reg_t    rd;
        opcode_t opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_t        rs1;
        funct3_t     funct3;
        reg_t        rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_t       rs2;
        reg_t       rs1;
        funct3_t    funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_t       rs2;
        reg_t       rs1;
        funct3_t    funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } sb_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_t        rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_t       rd;
        opcode_t    opcode;
    } uj_fmt_t;

    // All formats overlay the same 32-bit instruction word.
    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        s_fmt_t  s;
        sb_fmt_t sb;
        u_fmt_t  u;
        uj_fmt_t uj;
    } ir_t;

    // ========================================================================
    // Control encodings and stage structs
    // ========================================================================

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_t;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_I_IMM,
        OP2_S_IMM,
        OP2_B_IMM,
        OP2_U_IMM,
        OP2_J_IMM,
        OP2_FOUR
    } op2_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        pc_t pc;
        ir_t ir;
    } fetch_t;

    typedef struct packed {
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        alu_op_t  alu_op;
        logic     we;
    } ctrl_t;

    typedef struct packed {
        data_t   op1;
        data_t   op2;
        alu_op_t alu_op;
        reg_t    rd;
        logic    we;
    } id_ex_t;

    typedef struct packed {
        reg_t  rd;
        data_t data;
        logic  we;
    } wb_t;

endpackage

//--- hw/rv_alu_core.sv
`timescale 1ns/1ps

module rv_alu_core #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  riscv_pkg::fetch_t in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output riscv_pkg::wb_t    out_data
);
    import riscv_pkg::*;

    logic    advance;
    logic    out_fire;
    logic    q_empty;
    fetch_t  q_data;
    ctrl_t   ctrl;
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    reg_t    raddr1;
    reg_t    raddr2;
    data_t   rdata1;
    data_t   rdata2;
    wb_t     ex_fwd;
    id_ex_t  id_ex;
    logic    id_ex_valid;

    // ========================================================================
    // Pipeline control
    // ========================================================================

    // All stages move together unless the output is stalled.
    assign advance  = out_ready || !out_valid;
    assign out_fire = out_valid && out_ready;

    instr_queue #(
        .DEPTH (FIFO_DEPTH)
    ) u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .pop      (advance),
        .empty    (q_empty),
        .out_data (q_data)
    );

    control_decoder u_ctrl (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    // The output register doubles as the older forwarding source.
    decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .in_valid    (!q_empty),
        .fetch       (q_data),
        .ctrl        (ctrl),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_fwd      (ex_fwd),
        .wb_fwd      (out_data),
        .id_ex       (id_ex),
        .id_ex_valid (id_ex_valid)
    );

    execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .id_ex       (id_ex),
        .id_ex_valid (id_ex_valid),
        .ex_fwd      (ex_fwd),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    // Architectural state updates only when a result is handed off.
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (out_data),
        .wen    (out_fire)
    );

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_alu_core -f sources.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_alu_core)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

//--- sources.f
hw/riscv_pkg.sv
hw/instr_queue.sv
hw/control_decoder.sv
hw/regfile.sv
hw/decode.sv
hw/execute.sv
hw/rv_alu_core.sv
verif/tb_rv_alu_core.sv

//--- verif/tb_rv_alu_core.sv
`timescale 1ns/1ps

module tb_rv_alu_core;
    import riscv_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int WAIT_LIMIT   = 200;
    localparam int READY_RANDOM = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_LOW    = 2;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    fetch_t in_data;
    logic   out_valid;
    logic   out_ready;
    wb_t    out_data;
    logic   out_fire;
    logic   fired;

    logic [31:0] lfsr;
    int          ready_mode;
    pc_t         next_pc;
    data_t       model_rf [32];
    wb_t         exp_q [$];
    wb_t         exp_head;
    logic        exp_avail;
    int          check_errors;
    int          timeout_errors;

    rv_alu_core #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #5 clk = ~clk;

    assign out_fire = out_valid && out_ready;

    // A transfer seen on the rising edge is retired on the following falling edge.
    always @(posedge clk) begin
        fired <= rst_n && out_fire;
    end

    // ========================================================================
    // Output checks
    // ========================================================================

    expected_present: assert property (@(posedge clk) disable iff (!rst_n)
        out_fire |-> exp_avail)
    else begin
        check_errors++;
        $display("Output transfer at %0t with no instruction left to retire", $time);
    end

    rd_match: assert property (@(posedge clk) disable iff (!rst_n)
        (out_fire && exp_avail) |-> (out_data.rd == exp_head.rd))
    else begin
        check_errors++;
        $display("[FAIL] %0t: rd is %0d, expected %0d", $time, out_data.rd, exp_head.rd);
    end

    we_match: assert property (@(posedge clk) disable iff (!rst_n)
        (out_fire && exp_avail) |-> (out_data.we == exp_head.we))
    else begin
        check_errors++;
        $display("[FAIL] %0t: we is %b, expected %b", $time, out_data.we, exp_head.we);
    end

    data_match: assert property (@(posedge clk) disable iff (!rst_n)
        (out_fire && exp_avail && exp_head.we) |-> (out_data.data == exp_head.data))
    else begin
        check_errors++;
        $display("[FAIL] %0t: x%0d data is %h, expected %h", $time, exp_head.rd,
                 out_data.data, exp_head.data);
    end

    // A stalled result must stay on the port unchanged.
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
        check_errors++;
        $display("[FAIL] %0t: output changed while out_ready was low", $time);
    end

    // ========================================================================
    // Random numbers and reference model
    // ========================================================================

    // Taps 32, 22, 2 and 1 give a maximal length sequence.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw(int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Register and immediate forms follow the same RV32I integer semantics.
    function automatic data_t alu_ref(logic [2:0] f3, logic alt, data_t a, data_t b);
        data_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic void refresh_head();
        exp_avail = (exp_q.size() != 0);
        if (exp_avail) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endfunction

    task automatic predict(input pc_t pc, input logic [31:0] ir);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [4:0] rd;
        data_t      a;
        data_t      b;
        data_t      imm_i;
        data_t      imm_u;
        data_t      res;
        logic       we;
        opc   = ir[6:0];
        f3    = ir[14:12];
        rd    = ir[11:7];
        a     = model_rf[ir[19:15]];
        b     = model_rf[ir[24:20]];
        imm_i = {{20{ir[31]}}, ir[31:20]};
        imm_u = {ir[31:12], 12'd0};
        res   = '0;
        we    = 1'b1;
        case (opc)
            OPC_OP:            res = alu_ref(f3, ir[30], a, b);
            OPC_OP_IMM:        res = alu_ref(f3, ir[30] && (f3 == 3'b101), a, imm_i);
            OPC_LUI:           res = imm_u;
            OPC_AUIPC:         res = pc + imm_u;
            OPC_JAL, OPC_JALR: res = pc + 32'd4;
            default:           we = 1'b0;
        endcase
        exp_q.push_back('{rd: rd, data: res, we: we});
        refresh_head();
        if (we && (rd != 5'd0)) begin
            model_rf[rd] = res;
        end
    endtask

    // ========================================================================
    // Instruction encoders
    // ========================================================================

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jal_word(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // ========================================================================
    // Driving and waiting
    // ========================================================================

    task automatic tick();
        @(negedge clk);
        if (fired && (exp_q.size() != 0)) begin
            exp_q.delete(0);
        end
        refresh_head();
        case (ready_mode)
            READY_HIGH: out_ready = 1'b1;
            READY_LOW:  out_ready = 1'b0;
            default:    out_ready = (draw(2) != 0);
        endcase
    endtask

    task automatic issue(input logic [31:0] instr);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = {next_pc, instr};
        // in_ready only changes on a rising edge, so this view holds until then.
        while (!in_ready && (waited < WAIT_LIMIT)) begin
            tick();
            waited++;
        end
        if (in_ready) begin
            predict(next_pc, instr);
            next_pc = next_pc + 32'd4;
            tick();
        end else begin
            timeout_errors++;
            $display("Timeout at %0t: the queue never accepted pc %h", $time, next_pc);
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < WAIT_LIMIT)) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout at %0t: %0d results never came out", $time, exp_q.size());
        end
    endtask

    // ========================================================================
    // Instruction sequences
    // ========================================================================

    // Every register gets a known value before anything reads it.
    task automatic init_regs();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int r = 1; r < 32; r++) begin
            hi = draw(20);
            lo = draw(12);
            issue(u_type(hi[19:0], 5'(r), OPC_LUI));
            issue(i_type(lo[11:0], 5'(r), 3'b000, 5'(r), OPC_OP_IMM));
        end
    endtask

    task automatic imm_ops(input int count);
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [4:0]  sh;
        for (int n = 0; n < count; n++) begin
            sel   = int'(draw(4)) % 11;
            rd    = 5'(draw(5));
            rs1   = 5'(draw(5));
            imm   = 12'(draw(12));
            upper = 20'(draw(20));
            sh    = 5'(draw(5));
            case (sel)
                0:  issue(i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM));
                1:  issue(i_type(imm, rs1, 3'b010, rd, OPC_OP_IMM));
                2:  issue(i_type(imm, rs1, 3'b011, rd, OPC_OP_IMM));
                3:  issue(i_type(imm, rs1, 3'b100, rd, OPC_OP_IMM));
                4:  issue(i_type(imm, rs1, 3'b110, rd, OPC_OP_IMM));
                5:  issue(i_type(imm, rs1, 3'b111, rd, OPC_OP_IMM));
                6:  issue(i_type({7'b0000000, sh}, rs1, 3'b001, rd, OPC_OP_IMM));
                7:  issue(i_type({7'b0000000, sh}, rs1, 3'b101, rd, OPC_OP_IMM));
                8:  issue(i_type({7'b0100000, sh}, rs1, 3'b101, rd, OPC_OP_IMM));
                9:  issue(u_type(upper, rd, OPC_LUI));
                default: issue(u_type(upper, rd, OPC_AUIPC));
            endcase
        end
    endtask

    // Each source is the destination of the instruction one or two back.
    task automatic dependent_ops(input int count);
        logic [4:0] hist1;
        logic [4:0] hist2;
        logic [4:0] src;
        logic [4:0] other;
        logic [4:0] rd;
        logic [2:0] f3;
        logic       alt;
        hist1 = 5'd1;
        hist2 = 5'd2;
        for (int n = 0; n < count; n++) begin
            src   = (draw(1) != 0) ? hist1 : hist2;
            other = 5'(draw(5));
            f3    = 3'(draw(3));
            alt   = (draw(1) != 0) && ((f3 == 3'b000) || (f3 == 3'b101));
            rd    = 5'(draw(5)) | 5'd1;
            if (draw(1) != 0) begin
                issue(r_type({1'b0, alt, 5'd0}, other, src, f3, rd));
            end else begin
                issue(r_type({1'b0, alt, 5'd0}, src, other, f3, rd));
            end
            hist2 = hist1;
            hist1 = rd;
        end
    endtask

    task automatic link_ops(input int count);
        logic [31:0] off;
        logic [4:0]  rd;
        logic [4:0]  rd2;
        logic [4:0]  rs1;
        logic [11:0] imm;
        for (int n = 0; n < count; n++) begin
            off = draw(21);
            rd  = 5'(draw(5)) | 5'd1;
            rd2 = 5'(draw(5)) | 5'd1;
            rs1 = 5'(draw(5));
            imm = 12'(draw(12));
            // The link into x0 is dropped, so x0 still reads as zero right after.
            issue(jal_word(off[20:0], 5'd0));
            issue(r_type(7'd0, 5'd0, 5'd0, 3'b000, rd));
            issue(i_type(imm, 5'd0, 3'b000, rd2, OPC_OP_IMM));
            issue(jal_word(off[20:0], rd));
            issue(i_type(imm, rs1, 3'b000, rd2, OPC_JALR));
            issue(r_type(7'b0100000, rd2, rd, 3'b000, rd));
            issue(i_type(imm, rs1, 3'b000, 5'd0, OPC_JALR));
            issue(r_type(7'd0, 5'd0, 5'd0, 3'b110, rd2));
        end
    endtask

    // Loads, stores, branches, fences and system ops have no effect here.
    task automatic bad_opcodes(input int count);
        logic [31:0] word;
        logic [6:0]  opc;
        logic [4:0]  rd2;
        for (int n = 0; n < count; n++) begin
            word = draw(32);
            rd2  = 5'(draw(5)) | 5'd1;
            case (int'(draw(3)) % 5)
                0:       opc = 7'b0000011;
                1:       opc = 7'b0100011;
                2:       opc = 7'b1100011;
                3:       opc = 7'b0001111;
                default: opc = 7'b1110011;
            endcase
            issue({word[31:7], opc});
            issue(r_type(7'd0, 5'd0, word[11:7], 3'b000, rd2));
        end
    endtask

    // With the output stalled, ID/EX and the output register hold one each.
    task automatic fill_while_stalled();
        int          accepted;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rd;
        drain();
        ready_mode = READY_LOW;
        tick();
        accepted = 0;
        while (in_ready && (accepted < FIFO_DEPTH + 8)) begin
            imm = draw(12);
            rs1 = draw(5);
            rd  = draw(5);
            issue(i_type(imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM));
            accepted++;
        end
        assert ((accepted == FIFO_DEPTH + 2) && !in_ready) else begin
            check_errors++;
            $display("[FAIL] %0t: in_ready fell after %0d transfers, expected %0d", $time,
                     accepted, FIFO_DEPTH + 2);
        end
        repeat (6) begin
            tick();
        end
        ready_mode = READY_RANDOM;
        drain();
    endtask

    task automatic finish_run();
        $display("Errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if ((check_errors == 0) && (timeout_errors == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        lfsr           = 32'h5bcd;
        ready_mode     = READY_HIGH;
        next_pc        = 32'h0000_1000;
        check_errors   = 0;
        timeout_errors = 0;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
        refresh_head();

        repeat (16) begin
            tick();
        end
        rst_n = 1'b1;
        assert (!out_valid && in_ready) else begin
            check_errors++;
            $display("[FAIL] %0t: after reset out_valid=%b in_ready=%b", $time,
                     out_valid, in_ready);
        end

        init_regs();
        imm_ops(40);
        dependent_ops(40);
        ready_mode = READY_RANDOM;
        imm_ops(40);
        dependent_ops(40);
        link_ops(6);
        bad_opcodes(8);
        fill_while_stalled();
        finish_run();
    end

endmodule
